// File: Makefile
SIM := verilator
VFLAGS := --binary --timing
TOP := gridDisplayTb
FILELIST := src.f
OBJDIR := obj_dir
PASS := Finished with no errors

BIN := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// File: source/controlPkg.sv
/*
 * Command opcodes and the selection state of the square grid.
 * Shared by the selection controller, the square generator and the top level.
 */
package controlPkg;

    // one-cycle command strobe, cmdNone means idle
    typedef enum logic [2:0] {
        cmdNone = 3'd0,
        cmdUp = 3'd1,
        cmdDown = 3'd2,
        cmdLeft = 3'd3,
        cmdRight = 3'd4,
        cmdMark = 3'd5
    } commandT;

    // marks indexed by row * 2 + col
    typedef struct packed {
        logic row;
        logic col;
        logic [3:0] marks;
    } selectionT;

endpackage

// File: source/displayPkg.sv
/*
 * Screen geometry, colors and the per-pixel position bundle for the display path.
 * Imported by the scan timer, square generator, frame composer and top level.
 */
package displayPkg;

    // visible area of the raster
    localparam int screenWidth = 320;
    localparam int screenHeight = 240;

    // sync pulses sit in the blanking region, active low
    localparam int hSyncStart = 336;
    localparam int hSyncWidth = 32;
    localparam int vSyncStart = 244;
    localparam int vSyncWidth = 2;

    // two by two grid of squares, column 0 / row 0 is the far (right, lower) one
    localparam int squareOrigin = 20;
    localparam int squarePitch = 110;
    localparam int squareSize = 90;
    // highlight box is centered on the selected square
    localparam int highlightHalf = 55;
    localparam int highlightCenter = 175;

    localparam int borderWidth = 2;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } colorT;

    localparam colorT blackColor = '{red: 4'h0, green: 4'h0, blue: 4'h0};
    localparam colorT backgroundColor = '{red: 4'h1, green: 4'h2, blue: 4'h4};
    localparam colorT borderColor = '{red: 4'hf, green: 4'hf, blue: 4'hf};
    localparam colorT squareColor = '{red: 4'h8, green: 4'h8, blue: 4'h8};
    localparam colorT markColor = '{red: 4'h2, green: 4'hc, blue: 4'h4};
    localparam colorT highlightColor = '{red: 4'hf, green: 4'hc, blue: 4'h0};

    // all fields describe the same pixel
    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
        logic visible;
        logic frameStart;
        logic hSync;
        logic vSync;
    } scanPosT;

endpackage

// File: source/frameComposer.sv
/*
 * Turns the square generator results into a 12-bit color with the border on top,
 * and delays the syncs so they leave together with the color of their pixel.
 */
module frameComposer import displayPkg::*; (
    input logic clk,
    input logic arstN,
    input scanPosT scanPos,
    input logic [3:0] marks,
    input logic squarePixel,
    input logic [1:0] squareIndex,
    input logic highlightPixel,
    output colorT rgb,
    output logic hSync,
    output logic vSync
);

    // position lined up with the generator results
    scanPosT posD;
    logic borderPixel;
    logic markBit;
    colorT colorNext;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // not visible and syncs idle until the first pixel arrives
            posD <= '{x: '0, y: '0, visible: 1'b0, frameStart: 1'b0,
                      hSync: 1'b1, vSync: 1'b1};
        end else begin
            posD <= scanPos;
        end
    end

    always_comb begin
        borderPixel = (int'(posD.x) < borderWidth) ||
                      (int'(posD.x) > screenWidth - borderWidth) ||
                      (int'(posD.y) < borderWidth) ||
                      (int'(posD.y) > screenHeight - borderWidth);
        markBit = marks[squareIndex];

        // priority from blanking down to background
        if (!posD.visible) begin
            colorNext = blackColor;
        end else if (borderPixel) begin
            colorNext = borderColor;
        end else if (squarePixel && markBit) begin
            colorNext = markColor;
        end else if (squarePixel) begin
            colorNext = squareColor;
        end else if (highlightPixel) begin
            colorNext = highlightColor;
        end else begin
            colorNext = backgroundColor;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rgb <= blackColor;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end else begin
            rgb <= colorNext;
            hSync <= posD.hSync;
            vSync <= posD.vSync;
        end
    end

endmodule

// File: source/gridDisplay.sv
/*
 * Top level of the selection screen: raster timing, selection control,
 * square generation and color composition. Output lags the raster by two clocks.
 */
module gridDisplay import displayPkg::*, controlPkg::*; #(
    // must cover the sync windows, so at least 368 by 246
    parameter int hTotal = 400,
    parameter int vTotal = 262
) (
    input logic clk,
    input logic arstN,
    input commandT cmd,
    output colorT rgb,
    output logic hSync,
    output logic vSync
);

    scanPosT scanPos;
    selectionT shownSel;
    logic squarePixel;
    logic [1:0] squareIndex;
    logic highlightPixel;

    scanTimer #(
        .hTotal(hTotal),
        .vTotal(vTotal)
    ) scanTimer_i (
        .clk(clk),
        .arstN(arstN),
        .scanPos(scanPos)
    );

    selectionControl selectionControl_i (
        .clk(clk),
        .arstN(arstN),
        .cmd(cmd),
        .frameStart(scanPos.frameStart),
        .shownSel(shownSel)
    );

    modSquareGenerator modSquareGenerator_i (
        .clk(clk),
        .arstN(arstN),
        .scanPos(scanPos),
        .shownSel(shownSel),
        .squarePixel(squarePixel),
        .squareIndex(squareIndex),
        .highlightPixel(highlightPixel)
    );

    frameComposer frameComposer_i (
        .clk(clk),
        .arstN(arstN),
        .scanPos(scanPos),
        .marks(shownSel.marks),
        .squarePixel(squarePixel),
        .squareIndex(squareIndex),
        .highlightPixel(highlightPixel),
        .rgb(rgb),
        .hSync(hSync),
        .vSync(vSync)
    );

endmodule

// File: source/modSquareGenerator.sv
/*
 * Reports whether the current pixel lies in one of the four gray squares, which
 * one it is, and whether it lies in the highlight box of the shown selection.
 */
module modSquareGenerator import displayPkg::*, controlPkg::*; (
    input logic clk,
    input logic arstN,
    input scanPosT scanPos,
    input selectionT shownSel,
    output logic squarePixel,
    output logic [1:0] squareIndex,
    output logic highlightPixel
);

    int posX;
    int posY;
    int lowX;
    int lowY;
    int centerX;
    int centerY;
    logic squareDetect;
    logic [1:0] indexDetect;
    logic highlightDetect;

    always_comb begin
        posX = int'(scanPos.x);
        posY = int'(scanPos.y);
        squareDetect = 1'b0;
        indexDetect = 2'd0;
        lowX = 0;
        lowY = 0;

        // walk the two by two grid, index 0 sits at the larger coordinates
        for (int row = 0; row < 2; row++) begin
            for (int col = 0; col < 2; col++) begin
                lowX = squareOrigin + squarePitch * (1 - col);
                lowY = squareOrigin + squarePitch * (1 - row);
                // open interval, edges belong to the background
                if (posX > lowX && posX < lowX + squareSize &&
                    posY > lowY && posY < lowY + squareSize) begin
                    squareDetect = 1'b1;
                    indexDetect = 2'(row * 2 + col);
                end
            end
        end

        // highlight box around the shown square
        centerX = highlightCenter - squarePitch * int'(shownSel.col);
        centerY = highlightCenter - squarePitch * int'(shownSel.row);
        highlightDetect = posX > centerX - highlightHalf && posX < centerX + highlightHalf &&
                          posY > centerY - highlightHalf && posY < centerY + highlightHalf;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            squarePixel <= 1'b0;
            squareIndex <= 2'd0;
            highlightPixel <= 1'b0;
        end else begin
            squarePixel <= squareDetect;
            squareIndex <= indexDetect;
            highlightPixel <= highlightDetect;
        end
    end

endmodule

// File: source/scanTimer.sv
/*
 * Raster counters walking one pixel per clock, with frame start and active-low syncs.
 * All fields of scanPos are registered together so they name the same pixel.
 */
module scanTimer import displayPkg::*; #(
    parameter int hTotal = 400,
    parameter int vTotal = 262
) (
    input logic clk,
    input logic arstN,
    output scanPosT scanPos
);

    localparam int hBits = $clog2(hTotal);
    localparam int vBits = $clog2(vTotal);

    logic [hBits-1:0] hCount;
    logic [hBits-1:0] hNext;
    // vertical counter may be wider than the 8-bit y field
    logic [vBits-1:0] vCount;
    logic [vBits-1:0] vNext;
    scanPosT posNext;

    always_comb begin
        hNext = hCount + 1'b1;
        vNext = vCount;
        // wrap at end of line, then at end of frame
        if (hCount == hBits'(hTotal - 1)) begin
            hNext = '0;
            if (vCount == vBits'(vTotal - 1)) begin
                vNext = '0;
            end else begin
                vNext = vCount + 1'b1;
            end
        end

        posNext.x = 9'(hNext);
        posNext.y = 8'(vNext);
        posNext.visible = (int'(hNext) < screenWidth) && (int'(vNext) < screenHeight);
        posNext.frameStart = (hNext == '0) && (vNext == '0);
        // syncs low inside their window
        posNext.hSync = !((int'(hNext) >= hSyncStart) &&
                          (int'(hNext) < hSyncStart + hSyncWidth));
        posNext.vSync = !((int'(vNext) >= vSyncStart) &&
                          (int'(vNext) < vSyncStart + vSyncWidth));
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hCount <= '0;
            vCount <= '0;
            // pixel (0,0) is held during reset
            scanPos <= '{x: '0, y: '0, visible: 1'b1, frameStart: 1'b1,
                         hSync: 1'b1, vSync: 1'b1};
        end else begin
            hCount <= hNext;
            vCount <= vNext;
            scanPos <= posNext;
        end
    end

endmodule

// File: source/selectionControl.sv
/*
 * Applies command strobes to a pending selection and hands it to the display
 * as the shown selection at frame start, so a frame never changes midway.
 */
module selectionControl import controlPkg::*; (
    input logic clk,
    input logic arstN,
    input commandT cmd,
    input logic frameStart,
    output selectionT shownSel
);

    selectionT pendingSel;
    selectionT pendingNext;
    logic [1:0] curIndex;

    // square index of the current pending selection
    assign curIndex = {pendingSel.row, pendingSel.col};

    always_comb begin
        pendingNext = pendingSel;
        case (cmd)
            // row 1 is the upper square
            cmdUp: begin
                pendingNext.row = 1'b1;
            end
            cmdDown: begin
                pendingNext.row = 1'b0;
            end
            // col 1 is the left square
            cmdLeft: begin
                pendingNext.col = 1'b1;
            end
            cmdRight: begin
                pendingNext.col = 1'b0;
            end
            cmdMark: begin
                pendingNext.marks[curIndex] = !pendingSel.marks[curIndex];
            end
            cmdNone: begin
                pendingNext = pendingSel;
            end
            default: begin
                // unused opcodes are ignored
                pendingNext = pendingSel;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pendingSel <= '0;
            shownSel <= '0;
        end else begin
            pendingSel <= pendingNext;
            // a command in the frame start cycle waits for the next frame
            if (frameStart) begin
                shownSel <= pendingSel;
            end
        end
    end

endmodule

// File: src.f
source/displayPkg.sv
source/controlPkg.sv
source/scanTimer.sv
source/selectionControl.sv
source/modSquareGenerator.sv
source/frameComposer.sv
source/gridDisplay.sv
tests/gridDisplayTb.sv

// File: tests/gridDisplayTb.sv
/*
 * Testbench for the selection screen. Drives command strobes on the falling edge,
 * keeps a model of the raster and the selection, and checks every pixel and sync.
 */
module gridDisplayTb import displayPkg::*, controlPkg::*; ();

    // short raster so a frame takes fewer cycles
    localparam int hTotalTb = 370;
    localparam int vTotalTb = 248;
    localparam int frameLen = hTotalTb * vTotalTb;
    localparam int timeoutCycles = frameLen + 100;

    typedef struct packed {
        colorT rgb;
        logic hSync;
        logic vSync;
    } pixelT;

    logic clk;
    logic arstN;
    commandT cmd;
    colorT rgb;
    logic hSync;
    logic vSync;

    // reference model of the raster and the selection
    int edgeCount;
    selectionT modelPending;
    // output lags the raster so the last two frames keep their selection
    selectionT frameSel [0:1];
    int markPixels;
    int highlightPixels;
    logic [31:0] rngState;

    gridDisplay #(
        .hTotal(hTotalTb),
        .vTotal(vTotalTb)
    ) gridDisplay_i (
        .clk(clk),
        .arstN(arstN),
        .cmd(cmd),
        .rgb(rgb),
        .hSync(hSync),
        .vSync(vSync)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        logic [31:0] v;
        v = state;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // command rules applied to the pending selection
    function automatic selectionT applyCommand(input selectionT sel, input commandT c);
        selectionT next;
        next = sel;
        case (c)
            cmdUp: next.row = 1'b1;
            cmdDown: next.row = 1'b0;
            cmdLeft: next.col = 1'b1;
            cmdRight: next.col = 1'b0;
            cmdMark: next.marks[{sel.row, sel.col}] = !sel.marks[{sel.row, sel.col}];
            default: next = sel;
        endcase
        return next;
    endfunction

    // expected color and syncs of one raster position
    function automatic pixelT expectPixel(input int x, input int y, input selectionT sel);
        pixelT p;
        logic inCol0;
        logic inCol1;
        logic inRow0;
        logic inRow1;
        logic [1:0] idx;
        int hiX;
        int hiY;
        logic inHigh;
        p.hSync = !(x >= hSyncStart && x < hSyncStart + hSyncWidth);
        p.vSync = !(y >= vSyncStart && y < vSyncStart + vSyncWidth);
        // open intervals with col 0 on the right and row 0 at the bottom
        inCol0 = x > squareOrigin + squarePitch && x < squareOrigin + squarePitch + squareSize;
        inCol1 = x > squareOrigin && x < squareOrigin + squareSize;
        inRow0 = y > squareOrigin + squarePitch && y < squareOrigin + squarePitch + squareSize;
        inRow1 = y > squareOrigin && y < squareOrigin + squareSize;
        idx = {inRow1, inCol1};
        hiX = sel.col ? highlightCenter - squarePitch : highlightCenter;
        hiY = sel.row ? highlightCenter - squarePitch : highlightCenter;
        inHigh = x > hiX - highlightHalf && x < hiX + highlightHalf &&
                 y > hiY - highlightHalf && y < hiY + highlightHalf;
        if (x >= screenWidth || y >= screenHeight) begin
            p.rgb = blackColor;
        end else if (x < 2 || x > 318 || y < 2 || y > 238) begin
            p.rgb = borderColor;
        end else if ((inCol0 || inCol1) && (inRow0 || inRow1)) begin
            p.rgb = sel.marks[idx] ? markColor : squareColor;
        end else if (inHigh) begin
            p.rgb = highlightColor;
        end else begin
            p.rgb = backgroundColor;
        end
        return p;
    endfunction

    task automatic compareColor(input colorT actual, input colorT expected);
        if (actual !== expected) begin
            $display("Error at %0t: rgb = %h, expected %h", $time, actual, expected);
            $display("Finished with errors");
            $fatal(1, "rgb mismatch");
        end
    endtask

    task automatic compareSync(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "sync mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "timeout");
    endtask

    // returns at the falling edge after the raster wraps into a new frame
    task automatic waitNextFrame();
        int startFrame;
        int cycles;
        startFrame = edgeCount / frameLen;
        cycles = 0;
        while (edgeCount / frameLen == startFrame) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeoutCycles) begin
                reportTimeout("the next frame");
            end
        end
    endtask

    // returns at the next falling edge where the raster is halfway through a frame
    task automatic waitMidFrame();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > timeoutCycles) begin
                reportTimeout("the middle of a frame");
            end
        end while (edgeCount % frameLen != frameLen / 2);
    endtask

    // one-cycle strobe issued from a falling edge
    task automatic issueCmd(input commandT c);
        cmd = c;
        @(negedge clk);
        cmd = cmdNone;
    endtask

    // outputs read here still hold the result of the previous edge
    always @(posedge clk) begin : checkOutputs
        pixelT expected;
        int pix;
        logic slot;
        if (!arstN) begin
            edgeCount = 0;
            modelPending = '0;
            frameSel[0] = '0;
            frameSel[1] = '0;
            markPixels = 0;
            highlightPixels = 0;
        end else begin
            if (edgeCount < 2) begin
                expected = '{rgb: blackColor, hSync: 1'b1, vSync: 1'b1};
            end else begin
                pix = edgeCount - 2;
                slot = 1'((pix / frameLen) % 2);
                expected = expectPixel(pix % hTotalTb, (pix / hTotalTb) % vTotalTb,
                                       frameSel[slot]);
            end
            compareColor(rgb, expected.rgb);
            compareSync("hSync", hSync, expected.hSync);
            compareSync("vSync", vSync, expected.vSync);
            if (rgb == markColor) begin
                markPixels++;
            end
            if (rgb == highlightColor) begin
                highlightPixels++;
            end
            // frame start takes pending before this edge's command lands
            if (edgeCount % frameLen == 0) begin
                frameSel[1'((edgeCount / frameLen) % 2)] = modelPending;
            end
            modelPending = applyCommand(modelPending, cmd);
            edgeCount++;
        end
    end

    initial begin
        arstN = 1'b0;
        cmd = cmdNone;
        rngState = 32'hbf31bfb3;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // frame 0 keeps the reset selection before the visit of all four squares
        waitMidFrame();
        issueCmd(cmdLeft);
        waitMidFrame();
        issueCmd(cmdUp);
        waitMidFrame();
        issueCmd(cmdRight);
        waitMidFrame();
        issueCmd(cmdDown);
        // repeated moves stay put
        waitMidFrame();
        issueCmd(cmdDown);
        issueCmd(cmdRight);
        // two commands in one frame show together
        waitMidFrame();
        issueCmd(cmdUp);
        issueCmd(cmdLeft);
        // mark and unmark one square before marking another
        waitMidFrame();
        issueCmd(cmdMark);
        waitMidFrame();
        issueCmd(cmdMark);
        waitMidFrame();
        issueCmd(cmdDown);
        issueCmd(cmdMark);
        // command in the frame start cycle waits one more frame
        waitNextFrame();
        issueCmd(cmdRight);
        waitMidFrame();

        // sparse random commands over a few frames
        for (int i = 0; i < 3 * frameLen; i++) begin
            rngState = nextRandom(rngState);
            if (rngState[19:10] == '0) begin
                cmd = commandT'(3'(rngState % 32'd6));
            end else begin
                cmd = cmdNone;
            end
            @(negedge clk);
        end
        cmd = cmdNone;
        waitNextFrame();
        waitNextFrame();

        if (markPixels == 0 || highlightPixels == 0) begin
            $display("The run never showed a marked square or a highlight box");
            $display("Finished with errors");
            $fatal(1, "incomplete run");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule
